//--- verification/exec_cases.txt
# columns: instr pc expected_result expected_branch_taken expected_illegal (all hex)
# rest of a line after the fifth column is free text
00500093 00000100 00000005 0 0  # addi x1, x0, 5
ffd00113 00000104 fffffffd 0 0  # addi x2, x0, -3
0f00c193 00000108 000000f5 0 0  # xori x3, x1, 0xf0
7f00e213 0000010c 000007f5 0 0  # ori x4, x1, 0x7f0
ff017293 00000110 fffffff0 0 0  # andi x5, x2, -16
00112313 00000114 00000001 0 0  # slti x6, x2, 1
00113393 00000118 00000000 0 0  # sltiu x7, x2, 1
00409413 0000011c 00000050 0 0  # slli x8, x1, 4
00415493 00000120 0fffffff 0 0  # srli x9, x2, 4
40115513 00000124 fffffffe 0 0  # srai x10, x2, 1
002085b3 00000128 00000002 0 0  # add x11, x1, x2
40158633 0000012c fffffffd 0 0  # sub x12, x11, x1
0041f6b3 00000130 000000f5 0 0  # and x13, x3, x4
0080e733 00000134 00000055 0 0  # or x14, x1, x8
0041c7b3 00000138 00000700 0 0  # xor x15, x3, x4
00109833 0000013c 000000a0 0 0  # sll x16, x1, x1
001158b3 00000140 07ffffff 0 0  # srl x17, x2, x1
40115933 00000144 ffffffff 0 0  # sra x18, x2, x1
001129b3 00000148 00000001 0 0  # slt x19, x2, x1
00113a33 0000014c 00000000 0 0  # sltu x20, x2, x1
12345ab7 00000150 12345000 0 0  # lui x21, 0x12345
00001b17 00000154 00001154 0 0  # auipc x22, 0x1
008000ef 00000158 0000015c 0 0  # jal x1, 8
000082e7 0000015c 00000160 0 0  # jalr x5, 0(x1)
00008bb3 00000160 0000015c 0 0  # add x23, x1, x0
00d18463 00000164 00000000 1 0  # beq x3, x13
00310463 00000168 ffffff08 0 0  # beq x2, x3
00d19463 0000016c 00000000 0 0  # bne x3, x13
00311463 00000170 ffffff08 1 0  # bne x2, x3
00314463 00000174 ffffff08 1 0  # blt x2, x3
0021c463 00000178 000000f8 0 0  # blt x3, x2
00315463 0000017c ffffff08 0 0  # bge x2, x3
0021d463 00000180 000000f8 1 0  # bge x3, x2
00316463 00000184 ffffff08 0 0  # bltu x2, x3
0021e463 00000188 000000f8 1 0  # bltu x3, x2
00317463 0000018c ffffff08 1 0  # bgeu x2, x3
0021f463 00000190 000000f8 0 0  # bgeu x3, x2
00040c33 00000194 00000050 0 0  # add x24, x8, x0
00708013 00000198 00000163 0 0  # addi x0, x1, 7
00000cb3 0000019c 00000000 0 0  # add x25, x0, x0
ffc1ad03 000001a0 000000f1 0 0  # lw x26, -4(x3)
00112623 000001a4 00000009 0 0  # sw x1, 12(x2)
fe122c23 000001a8 000007ed 0 0  # sw x1, -8(x4)
0ff0048f 000001ac 00000000 0 1  # fence, rd field 9
0000057f 000001b0 00000000 0 1  # unknown opcode, rd field 10
00048db3 000001b4 0fffffff 0 0  # add x27, x9, x0
00050e33 000001b8 fffffffe 0 0  # add x28, x10, x0

//--- project.f
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/decode_if.sv
design/alu_decoder.sv
design/instruction_decode.sv
design/register_file.sv
design/alu.sv
design/exec_core.sv
verification/exec_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --top-module exec_core_tb -f project.f -o exec_core_sim &&
./obj_dir/exec_core_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;
  import rv_isa_pkg::*;

  localparam int max_cases    = 256;  // bound on lines taken from the case file
  localparam int open_tries   = 8;
  localparam int reset_cycles = 4;

  logic  clk;
  logic  arst_n;
  logic  instr_valid;
  word_t instr;
  word_t pc;
  word_t result;
  logic  branch_taken;
  logic  illegal;

  int case_idx;

  exec_core dut0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc           (pc),
    .result       (result),
    .branch_taken (branch_taken),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "stopped at case %0d", case_idx);
  endtask

  task automatic check_value(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h (case %0d)",
               name, got, expected, case_idx);
      abort_run();
    end
  endtask

  initial begin
    string line;
    word_t c_instr;
    word_t c_pc;
    word_t c_result;
    word_t c_branch;
    word_t c_illegal;
    int    fd;
    int    tries;
    int    waited;
    int    fields;
    int    got_line;

    case_idx = 0;
    fd       = 0;
    tries    = 0;
    while (fd == 0 && tries < open_tries) begin
      fd = $fopen("verification/exec_cases.txt", "r");
      tries++;
      if (fd == 0) @(posedge clk);
    end
    if (fd == 0) begin
      $display("could not open verification/exec_cases.txt");
      abort_run();
    end

    // wait for reset release, bounded
    waited = 0;
    while (arst_n !== 1'b1 && waited < 4 * reset_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("reset was not released in time");
      abort_run();
    end

    got_line = 1;
    while (got_line != 0 && case_idx < max_cases) begin
      got_line = $fgets(line, fd);
      if (got_line != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h",
                         c_instr, c_pc, c_result, c_branch, c_illegal);
        if (fields != 5) begin
          $display("malformed line in case file: %s", line);
          abort_run();
        end
        instr_valid <= 1'b1;
        instr       <= c_instr;
        pc          <= c_pc;
        @(negedge clk);  // outputs settled, write not yet done
        check_value("result", result, c_result);
        check_value("branch_taken", {31'b0, branch_taken}, c_branch);
        check_value("illegal", {31'b0, illegal}, c_illegal);
        case_idx++;
        @(posedge clk);  // rd written here
      end
    end
    instr_valid <= 1'b0;
    $fclose(fd);

    if (case_idx == 0) begin
      $display("no cases were read from the case file");
      abort_run();
    end else begin
      $display("%0d cases checked", case_idx);
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- design/exec_core.sv
`timescale 1ns/1ps

module exec_core (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              instr_valid,
  input  rv_isa_pkg::word_t instr,
  input  rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t result,
  output logic              branch_taken,
  output logic              illegal
);
  import rv_isa_pkg::*;

  word_t rs1_data;
  word_t rs2_data;

  decode_if dec_bus ();

  // decode fields and controls
  instruction_decode u_decode (
    .instr (instr),
    .dec   (dec_bus)
  );

  // write happens on the edge that ends a valid cycle
  register_file u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .we       (instr_valid),
    .rf       (dec_bus),
    .wdata    (result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .ex           (dec_bus),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (result),
    .branch_taken (branch_taken)
  );

  assign illegal = dec_bus.illegal;

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
  decode_if.ex              ex,
  input  rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t rs2_data,
  output rv_isa_pkg::word_t result,
  output logic              branch_taken
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t      a;
  word_t      b;
  logic [4:0] shamt;

  always_comb begin
    case (ex.src_a)
      src_a_pc:   a = pc;
      src_a_zero: a = '0;
      default:    a = rs1_data;
    endcase
  end

  assign b     = ex.use_imm ? ex.imm_ext : rs2_data;
  assign shamt = b[4:0];

  always_comb begin
    case (ex.alu_control)
      alu_add:      result = a + b;
      alu_sub:      result = a - b;
      alu_sll:      result = a << shamt;
      alu_slt:      result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu:     result = {31'b0, a < b};
      alu_xor:      result = a ^ b;
      alu_srl:      result = a >> shamt;
      alu_sra:      result = $signed(a) >>> shamt;
      alu_or:       result = a | b;
      alu_and:      result = a & b;
      alu_pass_imm: result = ex.imm_ext;
      alu_link:     result = pc + 32'd4;  // return address
      default:      result = '0;
    endcase
  end

  // branch decision straight from the register operands
  always_comb begin
    branch_taken = 1'b0;
    if (ex.opcode == b_type) begin
      case (ex.funct3)
        f3_beq:  branch_taken = (rs1_data == rs2_data);
        f3_bne:  branch_taken = (rs1_data != rs2_data);
        f3_blt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
        f3_bge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
        f3_bltu: branch_taken = (rs1_data < rs2_data);
        f3_bgeu: branch_taken = (rs1_data >= rs2_data);
        default: branch_taken = 1'b0;
      endcase
    end
  end

  // taken branches only come from a decoded, legal b_type
  always_comb begin
    assert (!branch_taken || (ex.opcode == b_type && !ex.illegal))
      else $error("branch_taken raised outside a branch");
  end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              we,
  decode_if.rf              rf,
  input  rv_isa_pkg::word_t wdata,
  output rv_isa_pkg::word_t rs1_data,
  output rv_isa_pkg::word_t rs2_data
);
  import rv_isa_pkg::*;

  localparam int depth = 2**reg_addr_w;

  word_t regs [depth];
  logic  wr_en;

  assign wr_en = we && rf.reg_write && (rf.rd != '0);  // x0 stays zero

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rf.rd] <= wdata;
    end
  end

  // combinational reads
  assign rs1_data = regs[rf.rs1];
  assign rs2_data = regs[rf.rs2];

  rs1_zero_reads_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    (rf.rs1 == '0) |-> (rs1_data == '0)
  ) else $error("x0 read returned nonzero data");

endmodule

//--- design/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
  input rv_isa_pkg::word_t instr,
  decode_if.dec            dec
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_t opcode;
  alu_op_t alu_op;
  logic    funct7_b5;

  assign opcode     = opcode_t'(instr[6:0]);
  assign dec.opcode = opcode;

  // funct fields, zero where the format has none
  always_comb begin
    dec.funct3 = 3'b000;
    funct7_b5  = 1'b0;
    case (opcode)
      r_type, i_type_logic: begin
        dec.funct3 = instr[14:12];
        funct7_b5  = instr[30];  // only meaningful for sub and the shifts
      end
      i_type_load, i_type_jalr, s_type, b_type: dec.funct3 = instr[14:12];
      default: ;
    endcase
  end

  // register indices per format
  always_comb begin
    dec.rd  = '0;
    dec.rs1 = '0;
    dec.rs2 = '0;
    case (opcode)
      r_type: begin
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
      end
      i_type_logic, i_type_load, i_type_jalr: begin
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
      end
      s_type, b_type: begin
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
      end
      u_type_auipc, u_type_lui, j_type: dec.rd = instr[11:7];
      default: ;
    endcase
  end

  // immediate extension
  always_comb begin
    case (opcode)
      i_type_logic, i_type_load, i_type_jalr:
        dec.imm_ext = {{20{instr[31]}}, instr[31:20]};
      s_type:
        dec.imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      b_type:
        dec.imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      j_type:
        dec.imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      u_type_auipc, u_type_lui:
        dec.imm_ext = {instr[31:12], 12'b0};
      default:
        dec.imm_ext = '0;
    endcase
  end

  // operation class, operand selects and write enable
  always_comb begin
    alu_op        = alu_op_unset;
    dec.src_a     = src_a_rs1;
    dec.use_imm   = 1'b1;
    dec.reg_write = 1'b1;
    case (opcode)
      r_type: begin
        alu_op      = alu_op_register;
        dec.use_imm = 1'b0;
      end
      i_type_logic: alu_op = alu_op_register;
      i_type_load, i_type_jalr: alu_op = alu_op_add;  // rs1 + imm
      s_type: begin
        alu_op        = alu_op_add;
        dec.reg_write = 1'b0;
      end
      b_type: begin
        alu_op        = alu_op_branch;
        dec.use_imm   = 1'b0;
        dec.reg_write = 1'b0;
      end
      j_type, u_type_auipc: begin
        alu_op    = alu_op_add;
        dec.src_a = src_a_pc;
      end
      u_type_lui: begin
        alu_op    = alu_op_add;
        dec.src_a = src_a_zero;
      end
      default: dec.reg_write = 1'b0;  // fence and anything unknown
    endcase
  end

  // supported opcode list, fence and unknown encodings fall outside it
  assign dec.illegal = !(opcode inside {r_type, i_type_logic, i_type_load, i_type_jalr,
                                        s_type, b_type, j_type, u_type_auipc, u_type_lui});

  alu_decoder u_alu_dec (
    .alu_op      (alu_op),
    .opcode      (opcode),
    .funct3      (dec.funct3),
    .funct7_b5   (funct7_b5),
    .alu_control (dec.alu_control)
  );

  // an illegal instruction must never reach the register file write port
  always_comb begin
    assert (!(dec.illegal && dec.reg_write))
      else $error("illegal instruction with reg_write set");
  end

endmodule

//--- design/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
  input  rv_ctrl_pkg::alu_op_t      alu_op,
  input  rv_isa_pkg::opcode_t       opcode,
  input  logic [2:0]                funct3,
  input  logic                      funct7_b5,
  output rv_ctrl_pkg::alu_control_t alu_control
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  always_comb begin
    alu_control = alu_none;
    case (alu_op)
      alu_op_add: begin
        case (opcode)
          u_type_lui:          alu_control = alu_pass_imm;
          j_type, i_type_jalr: alu_control = alu_link;
          default:             alu_control = alu_add;  // loads, stores, auipc
        endcase
      end
      alu_op_branch: alu_control = alu_sub;
      alu_op_register: begin
        case (funct3)
          f3_add_sub: begin
            // addi has no sub form, bit 30 there is immediate
            if (opcode == r_type && funct7_b5) begin
              alu_control = alu_sub;
            end else begin
              alu_control = alu_add;
            end
          end
          f3_sll:  alu_control = alu_sll;
          f3_slt:  alu_control = alu_slt;
          f3_sltu: alu_control = alu_sltu;
          f3_xor:  alu_control = alu_xor;
          f3_srl_sra: begin
            if (funct7_b5) begin
              alu_control = alu_sra;
            end else begin
              alu_control = alu_srl;
            end
          end
          f3_or:   alu_control = alu_or;
          f3_and:  alu_control = alu_and;
          default: alu_control = alu_none;
        endcase
      end
      default: alu_control = alu_none;  // unset
    endcase
  end

endmodule

//--- design/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_t      opcode;
  alu_control_t alu_control;
  word_t        imm_ext;
  logic [2:0]   funct3;
  reg_addr_t    rd;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  src_a_t       src_a;
  logic         use_imm;     // B operand is the immediate
  logic         reg_write;
  logic         illegal;

  modport dec (output opcode, alu_control, imm_ext, funct3, rd, rs1, rs2,
               src_a, use_imm, reg_write, illegal);
  modport rf  (input rs1, rs2, rd, reg_write);
  modport ex  (input opcode, alu_control, imm_ext, funct3, src_a, use_imm, illegal);

endinterface

//--- design/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // operation class chosen by the opcode
  typedef enum logic [1:0] {
    alu_op_add      = 2'd0,
    alu_op_branch   = 2'd1,
    alu_op_register = 2'd2,
    alu_op_unset    = 2'd3
  } alu_op_t;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_slt      = 4'd3,
    alu_sltu     = 4'd4,
    alu_xor      = 4'd5,
    alu_srl      = 4'd6,
    alu_sra      = 4'd7,
    alu_or       = 4'd8,
    alu_and      = 4'd9,
    alu_pass_imm = 4'd10,  // lui
    alu_link     = 4'd11,  // pc + 4 for jal and jalr
    alu_none     = 4'd12
  } alu_control_t;

  // A operand source
  typedef enum logic [1:0] {
    src_a_rs1  = 2'd0,
    src_a_pc   = 2'd1,
    src_a_zero = 2'd2
  } src_a_t;

endpackage

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;  // data width
  localparam int reg_addr_w = 5;   // register index width

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    r_type       = 7'b0110011,
    i_type_logic = 7'b0010011,
    i_type_load  = 7'b0000011,
    i_type_jalr  = 7'b1100111,
    s_type       = 7'b0100011,
    b_type       = 7'b1100011,
    j_type       = 7'b1101111,
    u_type_auipc = 7'b0010111,
    u_type_lui   = 7'b0110111,
    fence        = 7'b0001111
  } opcode_t;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // alu operations, shared by the register and immediate forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

endpackage
